// ==== src.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/reg_bank.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/reg_alu_core.sv
dv/core_checker.sv
dv/tb_reg_alu_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_reg_alu_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_reg_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_reg_alu_core
    import core_pkg::*;
();

    localparam int CLK_HALF = 50;  // 100 ns period
    localparam int N_RAND   = 40;
    localparam int SEED     = 11803;
    localparam data_t LDI_VAL [16] = '{8'h00, 8'h3C, 8'hC5, 8'hFF, 8'h01, 8'h80, 8'h0F, 8'hF0,
                                       8'h05, 8'h07, 8'hAA, 8'h55, 8'h03, 8'h12, 8'h7F, 8'h64};

    typedef struct packed {
        instr_t    word;
        reg_addr_t rd;
        data_t     data;
        logic      carry;
        logic      zero;
        logic      ill;
        logic      poke;  // Second strobe while busy
    } entry_t;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      busy;
    logic      result_valid;
    reg_addr_t result_rd;
    data_t     result_data;
    logic      carry;
    logic      zero;
    logic      illegal;
    logic      exp_use;     // Checker takes expected values from cur
    entry_t    cur;         // Row being applied
    entry_t    rows [$];
    int        value_errs;
    int        pulse_errs;
    int        checks;

    always #(CLK_HALF) clk = ~clk;

    reg_alu_core dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .busy         (busy),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .carry        (carry),
        .zero         (zero),
        .illegal      (illegal)
    );

    core_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .busy         (busy),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .carry        (carry),
        .zero         (zero),
        .illegal      (illegal),
        .exp_use      (exp_use),
        .exp_rd       (cur.rd),
        .exp_data     (cur.data),
        .exp_carry    (cur.carry),
        .exp_zero     (cur.zero),
        .exp_ill      (cur.ill),
        .value_errs   (value_errs),
        .pulse_errs   (pulse_errs),
        .checks       (checks)
    );

    task automatic add_row(input instr_t w, input reg_addr_t rd, input data_t d,
                           input logic c, input logic ill, input logic poke);
        entry_t row;
        row = '{w, rd, d, c, d == 8'h00, ill, poke};
        rows.push_back(row);
    endtask

    // One strobe on the falling edge, optional strobe while busy, then wait for idle
    task automatic send(input instr_t w, input logic poke);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        instr_valid = 1'b0;
        if (poke) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = 16'h00EE;  // LDI r0, would show up in a later read if taken
            @(negedge clk);
            instr_valid = 1'b0;
        end
        while (busy) begin
            @(negedge clk);
        end
    endtask

    initial begin
        instr_t w;
        int     i;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_use     = 1'b0;
        cur         = '0;
        void'($urandom(SEED));
        for (i = 0; i < 16; i++) begin  // Fill every register first
            add_row({4'h0, 4'(i), LDI_VAL[i]}, 4'(i), LDI_VAL[i], 1'b0, 1'b0, 1'b0);
        end
        add_row(16'h2834, 4'h8, 8'h00, 1'b1, 1'b0, 1'b0);  // FF + 01 wraps to zero
        add_row(16'h49AB, 4'h9, 8'h00, 1'b1, 1'b0, 1'b0);  // And keeps carry
        add_row(16'h5CAB, 4'hC, 8'hFF, 1'b1, 1'b0, 1'b0);
        add_row(16'h3D43, 4'hD, 8'h02, 1'b1, 1'b0, 1'b0);  // 01 - FF borrows
        add_row(16'h3EE6, 4'hE, 8'h70, 1'b0, 1'b0, 1'b0);
        add_row(16'h6F67, 4'hF, 8'hFF, 1'b0, 1'b0, 1'b0);
        add_row(16'h2112, 4'h1, 8'h01, 1'b1, 1'b0, 1'b0);  // 3C + C5 wraps
        add_row(16'h722C, 4'h2, 8'h80, 1'b1, 1'b0, 1'b0);  // Shift by 7
        add_row(16'h8AA8, 4'hA, 8'hAA, 1'b1, 1'b0, 1'b0);  // Shift by 0
        add_row(16'h877D, 4'h7, 8'h3C, 1'b1, 1'b0, 1'b0);  // Shift by 2, rt written above
        add_row(16'h7BB1, 4'hB, 8'hAA, 1'b1, 1'b0, 1'b0);
        add_row(16'h6444, 4'h4, 8'h00, 1'b1, 1'b0, 1'b0);  // rs = rt = rd
        add_row(16'h2333, 4'h3, 8'hFE, 1'b1, 1'b0, 1'b0);
        add_row(16'h1050, 4'h0, 8'h80, 1'b1, 1'b0, 1'b0);  // Move
        add_row(16'h2000, 4'h0, 8'h00, 1'b1, 1'b0, 1'b0);  // Reads the rd just written
        add_row(16'h3309, 4'h3, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(16'h9123, 4'h0, 8'h00, 1'b0, 1'b1, 1'b0);  // Illegal, aims at r1
        add_row(16'hF0FF, 4'h0, 8'h00, 1'b0, 1'b1, 1'b0);  // Illegal, aims at r0
        add_row(16'h1510, 4'h5, 8'h01, 1'b0, 1'b0, 1'b0);  // r1 untouched
        add_row(16'h1600, 4'h6, 8'h00, 1'b0, 1'b0, 1'b0);  // r0 untouched
        add_row(16'h277F, 4'h7, 8'h3B, 1'b1, 1'b0, 1'b1);  // Strobe while busy
        add_row(16'h5800, 4'h8, 8'h00, 1'b1, 1'b0, 1'b0);  // r0 still zero
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n  = 1'b1;
        exp_use = 1'b1;
        foreach (rows[j]) begin
            cur = rows[j];
            send(cur.word, cur.poke);
        end
        exp_use = 1'b0;  // Random section uses the checker's model
        repeat (N_RAND) begin
            w        = instr_t'($urandom);
            w[15:12] = 4'(1 + $urandom % 8);  // Move through shift right
            send(w, 1'b0);
        end
        repeat (3) @(negedge clk);  // Last zero flag check
        $display("Checks %0d, value errors %0d, pulse errors %0d", checks, value_errs, pulse_errs);
        if (checks > 0 && value_errs == 0 && pulse_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, 8 cycles per instruction plus margin
    initial begin
        longint limit;
        #1;
        limit = longint'(rows.size() + N_RAND) * 8 * 2 * CLK_HALF + 50 * 2 * CLK_HALF;
        #(limit);
        $display("Timeout: core still running after %0d ns", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            instr_valid,
    input  wire instr_t    instr,
    input  wire            busy,
    input  wire            result_valid,
    input  wire reg_addr_t result_rd,
    input  wire data_t     result_data,
    input  wire            carry,
    input  wire            zero,
    input  wire            illegal,
    input  wire            exp_use,      // Table row gives the expected values
    input  wire reg_addr_t exp_rd,
    input  wire data_t     exp_data,
    input  wire            exp_carry,
    input  wire            exp_zero,
    input  wire            exp_ill,
    output int             value_errs,   // Wrong values on a pulse
    output int             pulse_errs,   // Missing or extra pulses
    output int             checks
);

    data_t     regs [16];   // Reference registers
    logic      m_carry;     // Reference carry flag
    logic      in_flight;   // Taken, pulse not yet seen
    logic      model_busy;  // Instruction in flight at this edge
    int        age;         // Edges since the strobe was taken
    int        due;         // Edge at which the pulse is sampled
    logic      want_ill;
    reg_addr_t want_rd;
    data_t     want_data;
    logic      want_carry;
    logic      want_zero;
    logic      zero_due;    // Zero flag settles one edge after the write

    // Returns {carry, value} by the instruction set rules
    function automatic logic [8:0] apply_rule(input logic [3:0] code, input data_t a,
                                              input data_t b, input data_t imm, input logic c);
        int    sum;
        data_t dif;
        sum = int'(a) + int'(b);
        dif = a - b;
        case (code)
            OP_LDI:  return {c, imm};
            OP_ADD:  return {sum > 255, sum[7:0]};  // Carry out of bit 7
            OP_SUB:  return {b > a, dif};           // Borrow when b exceeds a
            OP_AND:  return {c, a & b};
            OP_OR:   return {c, a | b};
            OP_XOR:  return {c, a ^ b};
            OP_SHL:  return {c, a << b[2:0]};
            OP_SHR:  return {c, a >> b[2:0]};
            default: return {c, a};                 // Move
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks = checks + 1;
        if (got !== want) begin
            value_errs = value_errs + 1;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    // Predict the outcome of a taken instruction and update the model
    task automatic accept(input instr_t w);
        logic [8:0] res;
        res      = apply_rule(w[15:12], regs[w[7:4]], regs[w[3:0]], w[7:0], m_carry);
        want_ill = exp_use ? exp_ill : (w[15:12] > 4'd8);          // Codes 9..15
        due      = want_ill ? 1 : ((w[15:12] == OP_LDI) ? 3 : 5);  // Pulse seen one edge late
        if (!want_ill) begin
            regs[w[11:8]] = res[7:0];
            m_carry       = res[8];
        end
        want_rd    = exp_use ? exp_rd : w[11:8];
        want_data  = exp_use ? exp_data : res[7:0];
        want_carry = exp_use ? exp_carry : res[8];
        want_zero  = exp_use ? exp_zero : (res[7:0] == 8'h00);
        in_flight  = 1'b1;
        age        = 0;
    endtask

    // Everything sampled at the rising edge, before the core's flops update
    always @(posedge clk) begin
        if (!arst_n) begin
            in_flight  = 1'b0;
            zero_due   = 1'b0;
            m_carry    = 1'b0;   // Core clears carry on reset
            value_errs = 0;
            pulse_errs = 0;
            checks     = 0;
        end else begin
            model_busy = in_flight;
            check_val("busy", 32'(busy), 32'(model_busy));
            if (zero_due) begin
                check_val("zero", 32'(zero), 32'(want_zero));
                zero_due = 1'b0;
            end
            if (in_flight) begin
                age = age + 1;
            end
            if (result_valid && !(in_flight && !want_ill && age == due)) begin
                pulse_errs = pulse_errs + 1;
                $display("Unexpected result pulse for register %0d at %0t", result_rd, $time);
            end else if (result_valid) begin
                check_val("result_rd", 32'(result_rd), 32'(want_rd));
                check_val("result_data", 32'(result_data), 32'(want_data));
                check_val("carry", 32'(carry), 32'(want_carry));
                zero_due = 1'b1;
            end
            if (illegal && !(in_flight && want_ill && age == due)) begin
                pulse_errs = pulse_errs + 1;
                $display("Unexpected illegal pulse at %0t", $time);
            end
            if (in_flight && age == due) begin
                if (want_ill ? !illegal : !result_valid) begin
                    pulse_errs = pulse_errs + 1;
                    $display("Expected %s pulse did not arrive at %0t",
                             want_ill ? "illegal" : "result", $time);
                end
                checks    = checks + 1;
                in_flight = 1'b0;
            end
            if (instr_valid && !model_busy) begin  // Strobe while busy is dropped by the core
                accept(instr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_alu_core
    import core_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire         instr_valid,   // One-cycle strobe, ignored while busy
    input  wire instr_t instr,
    output logic        busy,
    output logic        result_valid,  // Write-back pulse
    output reg_addr_t   result_rd,
    output data_t       result_data,
    output logic        carry,
    output logic        zero,
    output logic        illegal        // Bad opcode pulse
);

    addr_sel_t addr_sel;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    op_t       op;
    data_t     imm;
    logic      cap_a;
    logic      cap_b;
    logic      exec_en;
    logic      wr_en;
    data_t     alu_out;
    logic      bank_wr;
    data_t     bank_wdata;
    reg_addr_t bank_addr;   // Shared read and write address
    data_t     bank_rdata;

    instr_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .addr_sel    (addr_sel),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .op          (op),
        .imm         (imm),
        .cap_a       (cap_a),
        .cap_b       (cap_b),
        .exec_en     (exec_en),
        .wr_en       (wr_en),
        .illegal     (illegal)
    );

    // Single port, so one source per cycle
    always_comb begin
        case (addr_sel)
            SEL_RT:  bank_addr = rt;
            SEL_RD:  bank_addr = rd;
            default: bank_addr = rs;
        endcase
    end

    alu_execute u_execute (
        .clk     (clk),
        .arst_n  (arst_n),
        .rdata   (bank_rdata),
        .cap_a   (cap_a),
        .cap_b   (cap_b),
        .exec_en (exec_en),
        .op      (op),
        .imm     (imm),
        .alu_out (alu_out),
        .carry   (carry)
    );

    result_writeback u_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .rd           (rd),
        .alu_out      (alu_out),
        .bank_wr      (bank_wr),
        .bank_wdata   (bank_wdata),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .zero         (zero)
    );

    reg_bank u_bank (
        .clk   (clk),
        .wr    (bank_wr),
        .addr  (bank_addr),
        .wdata (bank_wdata),
        .rdata (bank_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            wr_en,        // Write-back cycle from decode
    input  wire reg_addr_t rd,           // Destination register
    input  wire data_t     alu_out,      // Registered ALU result
    output logic           bank_wr,      // Bank write strobe
    output data_t          bank_wdata,
    output logic           result_valid, // Pulse, same cycle as the bank write
    output reg_addr_t      result_rd,
    output data_t          result_data,
    output logic           zero          // Last written value was zero
);

    logic is_zero;

    // Bank write, address comes from the top mux on rd
    assign bank_wr    = wr_en;
    assign bank_wdata = alu_out;

    // Result report alongside the write
    assign result_valid = wr_en;
    assign result_rd    = rd;
    assign result_data  = alu_out;

    assign is_zero = (alu_out == '0);

    // Updated with each write, held otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zero <= 1'b0;
        end else if (wr_en) begin
            zero <= is_zero;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute
    import core_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n,
    input  wire data_t rdata,    // Bank read data
    input  wire        cap_a,    // Take rdata as A
    input  wire        cap_b,    // Take rdata as B
    input  wire        exec_en,  // Register the result
    input  wire op_t   op,
    input  wire data_t imm,
    output data_t      alu_out,  // Registered result
    output logic       carry     // Carry or borrow of the last add or sub
);

    localparam int W = $bits(data_t);

    data_t          opa;         // Operand A, from rs
    data_t          opb;         // Operand B, from rt
    logic [W:0]     sum;         // Extra bit holds carry out
    logic [W:0]     diff;        // Extra bit holds borrow
    data_t          alu_next;
    logic           carry_next;

    always_ff @(posedge clk) begin
        if (cap_a) begin
            opa <= rdata;
        end
        if (cap_b) begin
            opb <= rdata;
        end
    end

    assign sum  = {1'b0, opa} + {1'b0, opb};
    assign diff = {1'b0, opa} - {1'b0, opb};  // MSB set when opb > opa

    always_comb begin
        alu_next   = opa;
        carry_next = carry;  // Logic and shift ops keep the flag
        case (op)
            OP_LDI: alu_next = imm;
            OP_MOV: alu_next = opa;
            OP_ADD: begin
                alu_next   = sum[W-1:0];
                carry_next = sum[W];
            end
            OP_SUB: begin
                alu_next   = diff[W-1:0];
                carry_next = diff[W];
            end
            OP_AND: alu_next = opa & opb;
            OP_OR:  alu_next = opa | opb;
            OP_XOR: alu_next = opa ^ opb;
            OP_SHL: alu_next = opa << opb[2:0];
            OP_SHR: alu_next = opa >> opb[2:0];  // Logical, zero fill
            default: alu_next = opa;             // Never reaches exec
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            alu_out <= alu_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
        end else if (exec_en) begin
            carry <= carry_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import core_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire         instr_valid,  // One-cycle strobe
    input  wire instr_t instr,
    output logic        busy,         // Instruction in flight
    output addr_sel_t   addr_sel,     // Bank address source
    output reg_addr_t   rd,
    output reg_addr_t   rs,
    output reg_addr_t   rt,
    output op_t         op,
    output data_t       imm,          // Load-immediate value
    output logic        cap_a,        // Latch bank data as A
    output logic        cap_b,        // Latch bank data as B
    output logic        exec_en,      // Register ALU result
    output logic        wr_en,        // Write-back cycle
    output logic        illegal       // One-cycle pulse on a bad opcode
);

    dec_state_t state;
    dec_state_t state_next;
    instr_t     instr_q;   // Latched instruction
    logic       pend;      // Instruction latched, path chosen next edge
    logic       take;      // Strobe accepted this cycle
    logic       bad_op;    // Opcode of the incoming word is out of range

    // Only a strobe in a fully idle core is taken
    assign take   = instr_valid && (state == ST_IDLE) && !pend;
    assign bad_op = instr[15:12] > OP_SHR;  // Codes 9..15

    always_ff @(posedge clk) begin
        if (take) begin
            instr_q <= instr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            pend    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            state   <= state_next;
            pend    <= take;
            illegal <= take && bad_op;  // High for the pending cycle only
        end
    end

    // Sequencer
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (pend && !illegal) begin  // Bad opcode drops back to idle
                    state_next = (op == OP_LDI) ? ST_EXEC : ST_READ_A;  // LDI needs no operands
                end
            end
            ST_READ_A: state_next = ST_READ_B;
            ST_READ_B: state_next = ST_EXEC;
            ST_EXEC:   state_next = ST_WRITE;
            ST_WRITE:  state_next = ST_IDLE;
            default:   state_next = ST_IDLE;
        endcase
    end

    // Instruction fields
    assign op  = op_t'(instr_q[15:12]);
    assign rd  = instr_q[11:8];
    assign rs  = instr_q[7:4];
    assign rt  = instr_q[3:0];
    assign imm = instr_q[7:0];  // Overlaps rs and rt

    // State decodes
    assign busy    = (state != ST_IDLE) || pend;
    assign cap_a   = (state == ST_READ_A);
    assign cap_b   = (state == ST_READ_B);
    assign exec_en = (state == ST_EXEC);
    assign wr_en   = (state == ST_WRITE);

    always_comb begin
        case (state)
            ST_READ_B: addr_sel = SEL_RT;
            ST_WRITE:  addr_sel = SEL_RD;  // Write goes to rd
            default:   addr_sel = SEL_RS;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module reg_bank
    import core_pkg::*;
#(
    parameter int addr_bits = `CORE_ADDR_BITS,  // Index width
    parameter int data_bits = `CORE_DATA_BITS   // Word width
) (
    input  wire        clk,
    input  wire        wr,     // Write strobe, data stored at the clock edge
    input  wire reg_addr_t addr,   // Shared read and write address
    input  wire data_t wdata,
    output data_t      rdata   // Combinational read at addr
);

    // Register storage, contents undefined until written
    logic [data_bits-1:0] mem [2**addr_bits];

    assign rdata = mem[addr];  // Asynchronous read port

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdata;  // Same address as the read
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    `include "core_params.svh"

    typedef logic [`CORE_ADDR_BITS-1:0]  reg_addr_t;  // Register index
    typedef logic [`CORE_DATA_BITS-1:0]  data_t;      // Register or ALU value
    typedef logic [`CORE_INSTR_BITS-1:0] instr_t;     // Instruction word

    // Opcode field, bits 15..12; codes above OP_SHR are illegal
    typedef enum logic [3:0] {
        OP_LDI = 4'd0,  // rd = imm
        OP_MOV = 4'd1,  // rd = rs
        OP_ADD = 4'd2,  // rd = rs + rt, carry out
        OP_SUB = 4'd3,  // rd = rs - rt, borrow
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_XOR = 4'd6,
        OP_SHL = 4'd7,  // rd = rs << rt[2:0]
        OP_SHR = 4'd8   // rd = rs >> rt[2:0]
    } op_t;

    // Decode sequencer
    typedef enum logic [2:0] {
        ST_IDLE,    // Waiting for a strobe
        ST_READ_A,  // Bank addressed by rs
        ST_READ_B,  // Bank addressed by rt
        ST_EXEC,    // ALU result registered
        ST_WRITE    // Bank addressed by rd, write and result pulse
    } dec_state_t;

    // Bank address source
    typedef enum logic [1:0] {
        SEL_RS,
        SEL_RT,
        SEL_RD
    } addr_sel_t;

endpackage

`default_nettype wire

// ==== rtl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Register file geometry

`define CORE_ADDR_BITS  4   // Register index width, 16 registers
`define CORE_DATA_BITS  8   // Register and ALU data width

// Instruction word

`define CORE_INSTR_BITS 16  // Opcode, rd, rs, rt in four nibbles

`endif
